// File: common/mcpu_pkg.sv
`default_nettype none

package mcpu_pkg;

  typedef logic [31:0] word_t;    // Data and instruction word
  typedef logic [4:0]  reg_num_t; // Register index

  typedef enum logic [1:0] {
    OPER_TYPE_ALU    = 2'd0,
    OPER_TYPE_BRANCH = 2'd1,
    OPER_TYPE_LSU    = 2'd2,
    OPER_TYPE_OTHER  = 2'd3
  } oper_type_t;

  // Operation handed from decode to the execute side
  typedef struct packed {
    logic [8:0]  execute_opcode;
    logic [1:0]  shift_type;
    logic [5:0]  shift_amount;
    oper_type_t  oper_type;
    reg_num_t    rd_num;
    logic        rd_we;
    logic        pred_we;
    word_t       sop;          // Second operand
    logic [11:0] lsu_offset;
    logic        invalid;
  } decoded_op_t;

  // Host register map
  localparam logic [7:0] ADDR_INST    = 8'h00;
  localparam logic [7:0] ADDR_PRED    = 8'h04;
  localparam logic [7:0] ADDR_RF_SEL  = 8'h08;
  localparam logic [7:0] ADDR_RF_DATA = 8'h0C;
  localparam logic [7:0] ADDR_STATUS  = 8'h10;

  localparam int NUM_PREDS = 3;

endpackage

`default_nettype wire

// File: hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int  DEPTH     = 8,
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk,
  input  wire logic     arst_n,
  input  wire logic     push,
  input  wire logic     pop,
  input  wire payload_t wdata,
  output payload_t      head,
  output payload_t      next,
  output logic          empty,
  output logic          full,
  output logic [7:0]    count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t           mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W-1:0]   rd_ptr_nxt;
  logic               do_push;
  logic               do_pop;

  assign empty   = (count == 8'd0);
  assign full    = (count == 8'(DEPTH));
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // Wrap explicitly so any depth works
  assign rd_ptr_nxt = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  assign head = empty ? '0 : mem[rd_ptr];
  assign next = (count >= 8'd2) ? mem[rd_ptr_nxt] : '0; // Zero unless two entries held

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= 8'd0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr_nxt;
      end
      if (do_push && !do_pop) begin
        count <= count + 8'd1;
      end else if (do_pop && !do_push) begin
        count <= count - 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/apb_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_host_regs (
  input  wire logic                            clk,
  input  wire logic                            arst_n,
  input  wire logic                            psel,
  input  wire logic                            penable,
  input  wire logic                            pwrite,
  input  wire logic [7:0]                      paddr,
  input  wire mcpu_pkg::word_t                 pwdata,
  output mcpu_pkg::word_t                      prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  output logic                                 inst_push,
  input  wire logic                            inst_full,
  input  wire logic [7:0]                      inst_count,
  input  wire logic [7:0]                      issue_count,
  output logic [mcpu_pkg::NUM_PREDS-1:0]       preds,
  output logic                                 rf_we,
  output mcpu_pkg::reg_num_t                   rf_waddr,
  output mcpu_pkg::word_t                      rf_wdata
);

  logic               access;
  logic               addr_ok;
  mcpu_pkg::reg_num_t rf_sel;

  assign access = psel & penable; // Access phase, no wait states
  assign pready = 1'b1;

  always_comb begin
    case (paddr)
      mcpu_pkg::ADDR_INST,
      mcpu_pkg::ADDR_PRED,
      mcpu_pkg::ADDR_RF_SEL,
      mcpu_pkg::ADDR_RF_DATA: addr_ok = 1'b1;
      mcpu_pkg::ADDR_STATUS:  addr_ok = ~pwrite; // Status is read only
      default:                addr_ok = 1'b0;
    endcase
  end

  assign inst_push = access & pwrite & (paddr == mcpu_pkg::ADDR_INST) & ~inst_full;
  assign rf_we     = access & pwrite & (paddr == mcpu_pkg::ADDR_RF_DATA);
  assign rf_waddr  = rf_sel;
  assign rf_wdata  = pwdata;

  // Error on bad address or a push into a full queue
  assign pslverr = access &
                   (~addr_ok | (pwrite & (paddr == mcpu_pkg::ADDR_INST) & inst_full));

  always_comb begin
    case (paddr)
      mcpu_pkg::ADDR_PRED:   prdata = {29'd0, preds};
      mcpu_pkg::ADDR_RF_SEL: prdata = {27'd0, rf_sel};
      mcpu_pkg::ADDR_STATUS: prdata = {16'd0, issue_count, inst_count};
      default:               prdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      preds  <= '0;
      rf_sel <= '0;
    end else if (access && pwrite) begin
      if (paddr == mcpu_pkg::ADDR_PRED) begin
        preds <= pwdata[2:0];
      end
      if (paddr == mcpu_pkg::ADDR_RF_SEL) begin
        rf_sel <= pwdata[4:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic               clk,
  input  wire logic               we,
  input  wire mcpu_pkg::reg_num_t waddr,
  input  wire mcpu_pkg::word_t    wdata,
  input  wire mcpu_pkg::reg_num_t rs_num,
  input  wire mcpu_pkg::reg_num_t rt_num,
  output mcpu_pkg::word_t         rs_data,
  output mcpu_pkg::word_t         rt_data
);

  mcpu_pkg::word_t regs [32];

  assign rs_data = regs[rs_num]; // Asynchronous read ports
  assign rt_data = regs[rt_num];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: decode/decode_logic.sv
`timescale 1ns/1ps
`default_nettype none

module decode_logic (
  input  wire mcpu_pkg::word_t                inst,
  input  wire mcpu_pkg::word_t                nextinst,
  input  wire logic [mcpu_pkg::NUM_PREDS-1:0] preds,
  input  wire logic [31:0]                    reg_busy,
  input  wire logic [mcpu_pkg::NUM_PREDS-1:0] pred_busy,
  input  wire mcpu_pkg::word_t                rs_data,
  input  wire mcpu_pkg::word_t                rt_data,
  input  wire logic                           prev_long_imm,
  output mcpu_pkg::reg_num_t                  rs_num,
  output mcpu_pkg::reg_num_t                  rt_num,
  output mcpu_pkg::decoded_op_t               op,
  output logic                                dep_stall,
  output logic                                long_imm
);

  logic [8:0]            opcode;
  logic [3:0]            pred_vals;
  logic [3:0]            pred_sb;
  logic                  pred_true;
  logic                  depend_rs;
  logic                  depend_rt;
  logic                  is_long;
  mcpu_pkg::decoded_op_t dec;

  assign opcode    = {inst[23:19], inst[13:10]};
  assign rt_num    = inst[18:14];
  assign rs_num    = inst[4:0];
  assign pred_vals = {1'b1, preds};     // Predicate 3 is always true
  assign pred_sb   = {1'b0, pred_busy};
  assign pred_true = pred_vals[inst[31:30]] ^ inst[29];

  always_comb begin
    dec                = '0;
    dec.execute_opcode = opcode;
    dec.rd_num         = inst[9:5];
    dec.oper_type      = mcpu_pkg::OPER_TYPE_ALU;
    dec.lsu_offset     = opcode[2] ? {inst[24:19], inst[13], inst[9:5]} : inst[24:13];
    depend_rs          = 1'b0;
    depend_rt          = 1'b0;
    is_long            = 1'b0;

    if (!inst[28]) begin // ALU short immediate
      dec.rd_we        = opcode[3:0] != 4'b0111; // Compares write a predicate
      dec.pred_we      = ~dec.rd_we;
      dec.shift_type   = 2'b11;
      dec.shift_amount = {1'b0, inst[17:14], 1'b0};
      dec.sop[9:0]     = inst[27:18];
      if (opcode[3]) begin
        dec.sop[14:10] = inst[4:0]; // One-operand form
      end else begin
        depend_rs = 1'b1;
      end
    end else if (inst[27:26] == 2'b01) begin // ALU register
      dec.sop          = rt_data;
      dec.rd_we        = opcode[3:0] != 4'b0111;
      dec.pred_we      = ~dec.rd_we;
      dec.shift_amount = {1'b0, inst[25:21]};
      dec.shift_type   = inst[20:19];
      depend_rt        = 1'b1;
      depend_rs        = ~opcode[3];
    end else if (inst[27:25] == 3'b001) begin // Load or store
      dec.oper_type = mcpu_pkg::OPER_TYPE_LSU;
      dec.sop       = rt_data;
      dec.rd_we     = ~opcode[2];  // Stores write nothing
      depend_rs     = 1'b1;
      depend_rt     = opcode[2];
    end else if (inst[27]) begin // Branch
      dec.oper_type = mcpu_pkg::OPER_TYPE_BRANCH;
      dec.rd_num    = 5'd31;       // Link register
      dec.rd_we     = inst[25];
      if (inst[26]) begin
        depend_rs       = 1'b1;
        dec.sop[23:4]   = inst[24:5];
      end else begin
        dec.sop[28:4]   = inst[24:0];
      end
    end else if (inst[24]) begin // Other class
      dec.oper_type = mcpu_pkg::OPER_TYPE_OTHER;
      dec.sop       = rt_data;
      case (opcode[8:5])
        4'b0001, 4'b0010, 4'b0011, 4'b0100: begin
          // BREAK, SYSCALL, FENCE, ERET need no operands
        end
        4'b0101, 4'b0111, 4'b1011: begin // FLUSH, MTC, MTHI
          depend_rs = 1'b1;
        end
        4'b0110, 4'b1010: begin          // MFC, MFHI
          dec.rd_we = 1'b1;
        end
        4'b1000, 4'b1001: begin          // MULT, DIV
          depend_rs = 1'b1;
          depend_rt = 1'b1;
          dec.rd_we = 1'b1;
        end
        default: begin
          dec.invalid = 1'b1;
        end
      endcase
    end else if (inst[22]) begin
      dec.invalid = 1'b1;          // Reserved
    end else if (inst[23]) begin   // Register shift
      depend_rs        = 1'b1;
      depend_rt        = 1'b1;
      dec.rd_we        = 1'b1;
      dec.shift_type   = inst[20:19];
      dec.shift_amount = {|rs_data[31:5], rs_data[4:0]}; // Top bit flags >= 32
      dec.sop          = rt_data;
    end else if (|inst[20:14]) begin
      dec.invalid = 1'b1;
    end else begin                 // Long immediate from the next word
      dec.sop     = nextinst;
      is_long     = 1'b1;
      depend_rs   = ~opcode[3];
      dec.pred_we = opcode[3:0] == 4'b0111;
      dec.rd_we   = ~dec.pred_we;
    end
  end

  // Tail word is empty, and a false predicate kills the writes
  always_comb begin
    op = dec;
    if (prev_long_imm) begin
      op = '0;
    end else if (!pred_true) begin
      op.rd_we   = 1'b0;
      op.pred_we = 1'b0;
    end
  end

  assign long_imm = is_long & ~prev_long_imm;

  assign dep_stall = ~prev_long_imm &
                     ((depend_rt & reg_busy[rt_num]) |
                      (depend_rs & reg_busy[rs_num]) |
                      pred_sb[inst[31:30]] |
                      (op.rd_we & reg_busy[op.rd_num]) |
                      (op.pred_we & pred_sb[op.rd_num[1:0]]));

endmodule

`default_nettype wire

// File: decode/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl (
  input  wire logic       clk,
  input  wire logic       arst_n,
  input  wire logic       inst_empty,
  input  wire logic [7:0] inst_count,
  input  wire logic       issue_full,
  input  wire logic       dep_stall,
  input  wire logic       long_imm,
  output logic            inst_pop,
  output logic            issue_push,
  output logic            sb_set,
  output logic            prev_long_imm
);

  typedef enum logic [1:0] {
    DECODE   = 2'd0,
    IMM_TAIL = 2'd1,
    HOLD     = 2'd2
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   can_issue;

  // Long immediates wait until the tail word is queued too
  assign can_issue = ~inst_empty & ~dep_stall & ~issue_full &
                     (~long_imm | (inst_count >= 8'd2));

  assign prev_long_imm = (state == IMM_TAIL);

  always_comb begin
    inst_pop   = 1'b0;
    issue_push = 1'b0;
    sb_set     = 1'b0;
    state_nxt  = state;
    case (state)
      IMM_TAIL: begin
        inst_pop  = ~inst_empty; // Drop the immediate word
        state_nxt = DECODE;
      end
      default: begin             // DECODE and HOLD
        if (can_issue) begin
          inst_pop   = 1'b1;
          issue_push = 1'b1;
          sb_set     = 1'b1;
          state_nxt  = long_imm ? IMM_TAIL : DECODE;
        end else begin
          state_nxt = HOLD;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= DECODE;
    end else begin
      state <= state_nxt;
    end
  end

endmodule

`default_nettype wire

// File: hw/scoreboard_timer.sv
`timescale 1ns/1ps
`default_nettype none

module scoreboard_timer #(
  parameter int WB_LATENCY = 3
) (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               set,
  input  wire mcpu_pkg::reg_num_t rd_num,
  input  wire logic               rd_we,
  input  wire logic               pred_we,
  output logic [31:0]             reg_busy,
  output logic [mcpu_pkg::NUM_PREDS-1:0] pred_busy
);

  localparam int CNT_W = $clog2(WB_LATENCY + 1);

  logic [CNT_W-1:0] reg_cnt  [32];
  logic [CNT_W-1:0] pred_cnt [mcpu_pkg::NUM_PREDS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        reg_cnt[i] <= '0;
      end
      for (int p = 0; p < mcpu_pkg::NUM_PREDS; p++) begin
        pred_cnt[p] <= '0;
      end
    end else begin
      for (int i = 0; i < 32; i++) begin
        if (set && rd_we && (rd_num == 5'(i))) begin
          reg_cnt[i] <= CNT_W'(WB_LATENCY); // Writeback pending
        end else if (reg_cnt[i] != '0) begin
          reg_cnt[i] <= reg_cnt[i] - 1'b1;
        end
      end
      for (int p = 0; p < mcpu_pkg::NUM_PREDS; p++) begin
        if (set && pred_we && (rd_num[1:0] == 2'(p))) begin
          pred_cnt[p] <= CNT_W'(WB_LATENCY);
        end else if (pred_cnt[p] != '0) begin
          pred_cnt[p] <= pred_cnt[p] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      reg_busy[i] = (reg_cnt[i] != '0);
    end
    for (int p = 0; p < mcpu_pkg::NUM_PREDS; p++) begin
      pred_busy[p] = (pred_cnt[p] != '0);
    end
  end

endmodule

`default_nettype wire

// File: hw/mcpu_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_decode_top #(
  parameter int INST_DEPTH  = 8,
  parameter int ISSUE_DEPTH = 4,
  parameter int WB_LATENCY  = 3
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pwrite,
  input  wire logic [7:0]            paddr,
  input  wire mcpu_pkg::word_t       pwdata,
  output mcpu_pkg::word_t            prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic                       out_valid,
  input  wire logic                  out_ready,
  output mcpu_pkg::decoded_op_t      out_op
);

  logic                          inst_push;
  logic                          inst_pop;
  logic                          inst_empty;
  logic                          inst_full;
  logic [7:0]                    inst_count;
  mcpu_pkg::word_t               inst;
  mcpu_pkg::word_t               nextinst;
  logic                          issue_push;
  logic                          issue_empty;
  logic                          issue_full;
  logic [7:0]                    issue_count;
  logic [mcpu_pkg::NUM_PREDS-1:0] preds;
  logic                          rf_we;
  mcpu_pkg::reg_num_t            rf_waddr;
  mcpu_pkg::word_t               rf_wdata;
  mcpu_pkg::reg_num_t            rs_num;
  mcpu_pkg::reg_num_t            rt_num;
  mcpu_pkg::word_t               rs_data;
  mcpu_pkg::word_t               rt_data;
  logic [31:0]                   reg_busy;
  logic [mcpu_pkg::NUM_PREDS-1:0] pred_busy;
  mcpu_pkg::decoded_op_t         dec_op;
  logic                          dep_stall;
  logic                          long_imm;
  logic                          prev_long_imm;
  logic                          sb_set;

  assign out_valid = ~issue_empty;

  apb_host_regs u_apb (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .inst_push, .inst_full, .inst_count, .issue_count, .preds,
    .rf_we, .rf_waddr, .rf_wdata
  );

  sync_fifo #(.DEPTH(INST_DEPTH), .payload_t(mcpu_pkg::word_t)) inst_fifo (
    .clk, .arst_n, .push(inst_push), .pop(inst_pop), .wdata(pwdata),
    .head(inst), .next(nextinst), .empty(inst_empty), .full(inst_full), .count(inst_count)
  );

  reg_file u_rf (
    .clk, .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
    .rs_num, .rt_num, .rs_data, .rt_data
  );

  decode_logic u_dec (
    .inst, .nextinst, .preds, .reg_busy, .pred_busy, .rs_data, .rt_data, .prev_long_imm,
    .rs_num, .rt_num, .op(dec_op), .dep_stall, .long_imm
  );

  issue_ctrl u_ctrl (
    .clk, .arst_n, .inst_empty, .inst_count, .issue_full, .dep_stall, .long_imm,
    .inst_pop, .issue_push, .sb_set, .prev_long_imm
  );

  scoreboard_timer #(.WB_LATENCY(WB_LATENCY)) u_sb (
    .clk, .arst_n, .set(sb_set), .rd_num(dec_op.rd_num),
    .rd_we(dec_op.rd_we), .pred_we(dec_op.pred_we), .reg_busy, .pred_busy
  );

  // Pop is ignored while empty, so out_ready can drive it directly
  sync_fifo #(.DEPTH(ISSUE_DEPTH), .payload_t(mcpu_pkg::decoded_op_t)) issue_fifo (
    .clk, .arst_n, .push(issue_push), .pop(out_ready), .wdata(dec_op),
    .head(out_op), .next(), .empty(issue_empty), .full(issue_full), .count(issue_count)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk; // 50% duty cycle

endmodule

`default_nettype wire

// File: testbench/tb_mcpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu_decode;

  localparam int INST_DEPTH  = 8;
  localparam int ISSUE_DEPTH = 4;
  localparam int WB_LATENCY  = 3;
  localparam logic [31:0] SEED = 32'he799;

  localparam int N_ALU   = 40;
  localparam int N_LSU   = 40;
  localparam int N_OTHER = 40;
  localparam int N_LONG  = 30;
  localparam int N_MIX   = 60;
  localparam int N_BP    = INST_DEPTH + ISSUE_DEPTH + 4;
  // A long immediate queues two words
  localparam int N_QUEUED    = N_ALU + N_LSU + N_OTHER + 2 * N_LONG + 2 * N_MIX + N_BP;
  localparam int CYCLE_LIMIT = 200 * N_QUEUED + 2000;

  // Instruction formats
  localparam int F_ALU_S   = 0;
  localparam int F_ALU_R   = 1;
  localparam int F_LSU     = 2;
  localparam int F_BR      = 3;
  localparam int F_OTHER   = 4;
  localparam int F_RSV     = 5;
  localparam int F_RSHIFT  = 6;
  localparam int F_LONG    = 7;
  localparam int F_BADLONG = 8;

  logic                  clk;
  logic                  arst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [7:0]            paddr;
  mcpu_pkg::word_t       pwdata;
  mcpu_pkg::word_t       prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  out_valid;
  logic                  out_ready = 1'b0;
  mcpu_pkg::decoded_op_t out_op;

  mcpu_pkg::word_t       mdl_regs [32];  // Register values as written over APB
  logic [2:0]            mdl_preds;
  mcpu_pkg::decoded_op_t exp_q [$];
  logic [63:0]           ready_pat;
  logic                  hold_low;
  int                    cycles = 0;
  int                    err_count;
  int                    test_count;
  int                    test_fail_count;
  int                    out_count;

  tb_clk_gen #(.PERIOD(40)) u_clk (.clk(clk));

  mcpu_decode_top #(
    .INST_DEPTH (INST_DEPTH),
    .ISSUE_DEPTH(ISSUE_DEPTH),
    .WB_LATENCY (WB_LATENCY)
  ) dut (
    .clk, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .out_valid, .out_ready, .out_op
  );

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input mcpu_pkg::word_t got,
                            input mcpu_pkg::word_t exp);
    if (got !== exp) begin
      $display("FAIL %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_op(input mcpu_pkg::decoded_op_t got, input mcpu_pkg::decoded_op_t exp);
    check_word("out_op.execute_opcode", 32'(got.execute_opcode), 32'(exp.execute_opcode));
    check_word("out_op.shift_type", 32'(got.shift_type), 32'(exp.shift_type));
    check_word("out_op.shift_amount", 32'(got.shift_amount), 32'(exp.shift_amount));
    check_word("out_op.oper_type", 32'(got.oper_type), 32'(exp.oper_type));
    check_word("out_op.rd_num", 32'(got.rd_num), 32'(exp.rd_num));
    check_word("out_op.rd_we", 32'(got.rd_we), 32'(exp.rd_we));
    check_word("out_op.pred_we", 32'(got.pred_we), 32'(exp.pred_we));
    check_word("out_op.sop", got.sop, exp.sop);
    check_word("out_op.lsu_offset", 32'(got.lsu_offset), 32'(exp.lsu_offset));
    check_word("out_op.invalid", 32'(got.invalid), 32'(exp.invalid));
  endtask

  function automatic int classify(input mcpu_pkg::word_t w);
    if (!w[28]) return F_ALU_S;
    if (w[27:26] == 2'b01) return F_ALU_R;
    if (w[27:25] == 3'b001) return F_LSU;
    if (w[27]) return F_BR;
    if (w[24]) return F_OTHER;
    if (w[22]) return F_RSV;
    if (w[23]) return F_RSHIFT;
    if (|w[20:14]) return F_BADLONG;
    return F_LONG;
  endfunction

  // Expected operation for one instruction word and the word after it
  function automatic mcpu_pkg::decoded_op_t model_decode(input mcpu_pkg::word_t w,
                                                         input mcpu_pkg::word_t tail);
    mcpu_pkg::decoded_op_t e;
    logic                  cmp;
    logic                  guard_val;
    mcpu_pkg::word_t       rs_val;
    mcpu_pkg::word_t       rt_val;
    cmp    = (w[13:10] == 4'b0111);
    rs_val = mdl_regs[w[4:0]];
    rt_val = mdl_regs[w[18:14]];
    e                = '0;
    e.execute_opcode = {w[23:19], w[13:10]};
    e.rd_num         = w[9:5];
    e.oper_type      = mcpu_pkg::OPER_TYPE_ALU;
    e.lsu_offset     = w[12] ? {w[24:19], w[13], w[9:5]} : w[24:13];
    case (classify(w))
      F_ALU_S: begin
        e.rd_we        = ~cmp;
        e.pred_we      = cmp;
        e.shift_type   = 2'b11;
        e.shift_amount = {1'b0, w[17:14], 1'b0};
        e.sop          = {17'd0, (w[13] ? w[4:0] : 5'd0), w[27:18]};
      end
      F_ALU_R: begin
        e.rd_we        = ~cmp;
        e.pred_we      = cmp;
        e.shift_type   = w[20:19];
        e.shift_amount = {1'b0, w[25:21]};
        e.sop          = rt_val;
      end
      F_LSU: begin
        e.oper_type = mcpu_pkg::OPER_TYPE_LSU;
        e.rd_we     = ~w[12];  // Loads only
        e.sop       = rt_val;
      end
      F_BR: begin
        e.oper_type = mcpu_pkg::OPER_TYPE_BRANCH;
        e.rd_num    = 5'd31;
        e.rd_we     = w[25];
        e.sop       = w[26] ? {8'd0, w[24:5], 4'd0} : {3'd0, w[24:0], 4'd0};
      end
      F_OTHER: begin
        e.oper_type = mcpu_pkg::OPER_TYPE_OTHER;
        e.sop       = rt_val;
        case (w[23:20])
          4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd7, 4'd11: begin
            e.rd_we = 1'b0;
          end
          4'd6, 4'd8, 4'd9, 4'd10: begin
            e.rd_we = 1'b1;
          end
          default: begin
            e.invalid = 1'b1;
          end
        endcase
      end
      F_RSHIFT: begin
        e.rd_we        = 1'b1;
        e.shift_type   = w[20:19];
        e.shift_amount = {|rs_val[31:5], rs_val[4:0]};
        e.sop          = rt_val;
      end
      F_LONG: begin
        e.sop     = tail;
        e.pred_we = cmp;
        e.rd_we   = ~cmp;
      end
      default: begin
        e.invalid = 1'b1;
      end
    endcase
    guard_val = (w[31:30] == 2'd3) ? 1'b1 : mdl_preds[w[31:30]];
    if (!(guard_val ^ w[29])) begin  // Predicate false, no writes
      e.rd_we   = 1'b0;
      e.pred_we = 1'b0;
    end
    return e;
  endfunction

  function automatic mcpu_pkg::word_t make_word(input int form, input logic narrow);
    mcpu_pkg::word_t w;
    w = $urandom;
    if (narrow) begin  // Few registers, many dependencies
      w[4:0]   = w[4:0] & 5'd3;
      w[9:5]   = w[9:5] & 5'd3;
      w[18:14] = w[18:14] & 5'd3;
    end
    if ($urandom % 4 == 0) begin
      w[13:10] = 4'b0111;  // Compare
    end
    case (form)
      F_ALU_S:  w[28] = 1'b0;
      F_ALU_R:  w[28:26] = 3'b101;
      F_LSU:    w[28:25] = 4'b1001;
      F_BR:     w[28:27] = 2'b11;
      F_OTHER:  w[28:24] = 5'b10001;
      F_RSV: begin
        w[28:24] = 5'b10000;
        w[22]    = 1'b1;
      end
      F_RSHIFT: begin
        w[28:24] = 5'b10000;
        w[23:22] = 2'b10;
      end
      F_LONG: begin
        w[28:24] = 5'b10000;
        w[23:22] = 2'b00;
        w[20:14] = '0;
      end
      default: begin
        w[28:24] = 5'b10000;
        w[23:22] = 2'b00;
        if (w[20:14] == '0) begin
          w[14] = 1'b1;
        end
      end
    endcase
    return w;
  endfunction

  function automatic int pick_form(input logic [8:0] mask);
    int f;
    do begin
      f = $urandom % 9;
    end while (!mask[f]);
    return f;
  endfunction

  // One APB transfer: setup, access, idle
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input mcpu_pkg::word_t wdata,
                          output mcpu_pkg::word_t rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    check_bit("pready", pready, 1'b1);  // No wait states
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input mcpu_pkg::word_t data,
                           input logic exp_err);
    mcpu_pkg::word_t rd;
    logic            err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_bit("pslverr", err, exp_err);
  endtask

  task automatic apb_read_check(input logic [7:0] addr, input mcpu_pkg::word_t exp);
    mcpu_pkg::word_t rd;
    logic            err;
    apb_xfer(1'b0, addr, '0, rd, err);
    check_word("prdata", rd, exp);
    check_bit("pslverr", err, 1'b0);
  endtask

  task automatic load_reg(input mcpu_pkg::reg_num_t idx, input mcpu_pkg::word_t val);
    apb_write(mcpu_pkg::ADDR_RF_SEL, 32'(idx), 1'b0);
    apb_write(mcpu_pkg::ADDR_RF_DATA, val, 1'b0);
    mdl_regs[idx] = val;
  endtask

  task automatic set_preds();
    mcpu_pkg::word_t p;
    p = $urandom;
    mdl_preds = p[2:0];
    apb_write(mcpu_pkg::ADDR_PRED, p, 1'b0);
    apb_read_check(mcpu_pkg::ADDR_PRED, {29'd0, p[2:0]});
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic finish_test(input string name, input int words, input int ops_exp,
                             input int errs_before, input int outs_before);
    int ops;
    ops = out_count - outs_before;
    if (ops != ops_exp) begin
      $display("test %s: %0d operations came out but %0d were expected", name, ops, ops_exp);
      err_count++;
    end
    test_count++;
    if (err_count == errs_before) begin
      $display("test %-14s ok     (%0d words, %0d ops)", name, words, ops);
    end else begin
      test_fail_count++;
      $display("test %-14s failed (%0d errors)", name, err_count - errs_before);
    end
  endtask

  task automatic run_test(input string name, input logic [8:0] mask, input int n,
                          input logic narrow);
    int                 errs_before;
    int                 outs_before;
    int                 queued;
    int                 f;
    mcpu_pkg::word_t    w;
    mcpu_pkg::word_t    tail;
    mcpu_pkg::reg_num_t idx;
    mcpu_pkg::word_t    val;
    errs_before = err_count;
    outs_before = out_count;
    queued      = 0;
    set_preds();
    for (int k = 0; k < 4; k++) begin
      idx = 5'($urandom % 32);
      val = $urandom;
      load_reg(idx, val);
    end
    for (int i = 0; i < n; i++) begin
      // Keep the instruction queue from filling
      while (exp_q.size() >= INST_DEPTH / 2) begin
        @(negedge clk);
      end
      f    = pick_form(mask);
      w    = make_word(f, narrow);
      tail = $urandom;
      exp_q.push_back(model_decode(w, tail));
      apb_write(mcpu_pkg::ADDR_INST, w, 1'b0);
      queued++;
      if (f == F_LONG) begin
        apb_write(mcpu_pkg::ADDR_INST, tail, 1'b0);
        queued++;
      end
    end
    wait_drain();
    finish_test(name, queued, n, errs_before, outs_before);
  endtask

  task automatic run_backpressure();
    int              errs_before;
    int              outs_before;
    logic            exp_err;
    logic            err;
    mcpu_pkg::word_t w;
    mcpu_pkg::word_t rd;
    mcpu_pkg::word_t full_status;
    errs_before = err_count;
    outs_before = out_count;
    full_status = {16'd0, 8'(ISSUE_DEPTH), 8'(INST_DEPTH)};
    set_preds();
    hold_low = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      w       = make_word(F_ALU_S, 1'b0);
      w[31:29] = 3'b110;   // Always true guard
      w[13:10] = 4'b1000;  // One-operand form
      w[9:5]   = 5'(i);    // Distinct destinations
      exp_err  = (i >= INST_DEPTH + ISSUE_DEPTH);
      if (!exp_err) begin
        exp_q.push_back(model_decode(w, '0));
      end
      apb_write(mcpu_pkg::ADDR_INST, w, exp_err);
    end
    repeat (4) @(negedge clk);
    apb_read_check(mcpu_pkg::ADDR_STATUS, full_status);
    apb_write(8'h14, $urandom, 1'b1);                  // Unknown address
    apb_write(mcpu_pkg::ADDR_STATUS, $urandom, 1'b1);  // Status is read only
    apb_xfer(1'b0, 8'h3C, '0, rd, err);
    check_bit("pslverr", err, 1'b1);
    apb_read_check(mcpu_pkg::ADDR_STATUS, full_status);
    hold_low = 1'b0;
    wait_drain();
    apb_read_check(mcpu_pkg::ADDR_STATUS, '0);
    finish_test("backpressure", N_BP, INST_DEPTH + ISSUE_DEPTH, errs_before, outs_before);
  endtask

  // Output side, ready from a fixed random pattern
  always @(negedge clk) begin
    out_ready = ~hold_low & ready_pat[cycles % 64];
    #1;
    if (arst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("an operation came out while none was expected");
        err_count++;
      end else begin
        check_op(out_op, exp_q.pop_front());
      end
      out_count++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d operations never came out", cycles, exp_q.size());
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(SEED));
    ready_pat       = {$urandom, $urandom};
    arst_n          = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    hold_low        = 1'b0;
    mdl_preds       = '0;
    err_count       = 0;
    test_count      = 0;
    test_fail_count = 0;
    out_count       = 0;
    repeat (10) @(negedge clk);
    arst_n = 1'b1;
    apb_read_check(mcpu_pkg::ADDR_STATUS, '0);  // Both queues empty
    for (int i = 0; i < 32; i++) begin
      load_reg(5'(i), $urandom);
    end
    run_test("alu_forms", 9'b0_0000_0011, N_ALU, 1'b0);
    run_test("lsu_branch", 9'b0_0000_1100, N_LSU, 1'b0);
    run_test("other_invalid", 9'b1_0111_0000, N_OTHER, 1'b0);
    run_test("long_imm", 9'b0_1000_0001, N_LONG, 1'b0);
    run_test("pred_depend", 9'b1_1111_1111, N_MIX, 1'b1);
    run_backpressure();
    $display("%0d tests, %0d failed, %0d check errors, %0d operations checked",
             test_count, test_fail_count, err_count, out_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mcpu_decode.f
common/mcpu_pkg.sv
hw/sync_fifo.sv
hw/apb_host_regs.sv
hw/reg_file.sv
decode/decode_logic.sv
decode/issue_ctrl.sv
hw/scoreboard_timer.sv
hw/mcpu_decode_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mcpu_decode.sv

// File: Makefile
# Verilator build for the decode-and-issue stage

VERILATOR ?= verilator
TOP       ?= tb_mcpu_decode
FILELIST  ?= mcpu_decode.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST PASSED" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
